/* sim.f */
hw/conv_pkg.sv
hw/conv_sequencer.sv
hw/filter_mac.sv
hw/requantizer.sv
hw/conv_layer.sv
verif/conv_layer_props.sv
verif/tb_conv_layer.sv

/* Makefile */
# Verilator build and run for the conv_layer testbench

VERILATOR   ?= verilator
TOP         ?= tb_conv_layer
FILELIST    ?= sim.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS   ?= +verilator+error+limit+$(ERROR_LIMIT)
PASS_TEXT   ?= All tests passed

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_conv_layer.sv */
`default_nettype none

module tb_conv_layer;

    localparam int WAIT_LIMIT = 200;            // Cycles before a wait gives up
    localparam int NUM_RAND   = 40;             // Random windows

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    conv_pkg::act_window_t in_window;
    logic                  busy;
    logic                  out_valid;
    conv_pkg::filt_idx_t   out_filter;
    conv_pkg::out_t        out_value;

    logic [31:0] lcg_state;                     // LCG state
    int          exp_filter_q [$];              // Expected filter order
    int          exp_value_q [$];               // Expected results
    int          mismatch_cnt;                  // Wrong values
    int          other_err_cnt;                 // Protocol and timeout errors
    bit          window_seen;                   // First window driven

    conv_layer UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_window  (in_window),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_filter (out_filter),
        .out_value  (out_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // Period 40
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the most random
    function automatic conv_pkg::act_window_t random_window();
        conv_pkg::act_window_t w;
        logic [31:0]           r;
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                r       = lcg_next();
                w[c][t] = r[23:16];
            end
        end
        return w;
    endfunction

    function automatic conv_pkg::act_window_t fill_window(input logic [7:0] v);
        conv_pkg::act_window_t w;
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                w[c][t] = v;
            end
        end
        return w;
    endfunction

    // Sum of products, floor shift, symmetric clip
    function automatic int model_filter(input conv_pkg::act_window_t w, input int f);
        int acc;
        int q;
        acc = 0;
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                acc += int'(w[c][t]) * int'(conv_pkg::WEIGHTS[f][c][t]);
            end
        end
        q = acc >>> conv_pkg::OUT_SHIFT;
        if (q > conv_pkg::SAT_MAX) begin
            q = conv_pkg::SAT_MAX;
        end else if (q < -conv_pkg::SAT_MAX) begin
            q = -conv_pkg::SAT_MAX;
        end
        return q;
    endfunction

    task automatic expect_window(input conv_pkg::act_window_t w);
        for (int f = 0; f < conv_pkg::NUM_FILTERS; f++) begin
            exp_filter_q.push_back(f);
            exp_value_q.push_back(model_filter(w, f));
        end
    endtask

    // One-cycle strobe from the current edge, layer must be free
    task automatic strobe_window(input conv_pkg::act_window_t w);
        in_valid    <= 1'b1;
        in_window   <= w;
        window_seen  = 1'b1;
        @(negedge clk);
        assert (!busy) else begin
            other_err_cnt++;
            $display("Window at %0t offered while the layer was busy", $time);
        end
        @(posedge clk);                         // Accepting edge
        in_valid <= 1'b0;
    endtask

    // Strobes that land while busy and must be ignored
    task automatic drop_strobes();
        for (int k = 0; k < conv_pkg::NUM_FILTERS - 1; k++) begin
            in_valid  <= 1'b1;
            in_window <= random_window();
            @(negedge clk);
            assert (busy) else begin
                other_err_cnt++;
                $display("Busy was low at %0t during a strobe meant to be dropped", $time);
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_idle(output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = !busy;
        if (!ok) begin
            other_err_cnt++;
            $display("Timeout at %0t: busy never went low", $time);
        end else begin
            @(posedge clk);                     // Back on a driving edge
        end
    endtask

    task automatic wait_drain(output bit ok);
        int n;
        n = 0;
        while (exp_filter_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (exp_filter_q.size() == 0);
        if (!ok) begin
            other_err_cnt++;
            $display("Timeout at %0t: %0d results never came out", $time, exp_filter_q.size());
        end else begin
            repeat (2 * conv_pkg::NUM_FILTERS) @(negedge clk);  // Quiet period for strays
        end
    endtask

    task automatic run_tests(output bit ok);
        conv_pkg::act_window_t w;
        wait_idle(ok);                          // Saturating corners
        if (!ok) return;
        w = fill_window(8'hFF);
        expect_window(w);
        strobe_window(w);
        wait_idle(ok);
        if (!ok) return;
        w = fill_window(8'h00);
        expect_window(w);
        strobe_window(w);
        wait_idle(ok);                          // Strobes while busy
        if (!ok) return;
        w = random_window();
        expect_window(w);
        strobe_window(w);
        drop_strobes();
        for (int i = 0; i < NUM_RAND; i++) begin
            w = random_window();
            if (i % 2 == 1) begin
                repeat (conv_pkg::NUM_FILTERS - 1) @(posedge clk);  // First free edge
            end else begin
                wait_idle(ok);
                if (!ok) return;
            end
            expect_window(w);
            strobe_window(w);
        end
        wait_drain(ok);
    endtask

    // Output checker, sampled mid-cycle
    always @(negedge clk) begin : scoreboard
        int exp_f;
        int exp_v;
        if (rst_n && out_valid) begin
            if (exp_filter_q.size() == 0) begin
                other_err_cnt++;
                $display("Unexpected output at %0t for filter %0d", $time, out_filter);
            end else begin
                exp_f = exp_filter_q.pop_front();
                exp_v = exp_value_q.pop_front();
                assert (int'(out_filter) == exp_f && int'(out_value) == exp_v) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: filter %0d value %0d, expected filter %0d value %0d",
                             $time, out_filter, out_value, exp_f, exp_v);
                end
            end
        end
        if (rst_n && !window_seen) begin
            assert (!busy && !out_valid) else begin
                other_err_cnt++;
                $display("Busy or out_valid high at %0t before any window", $time);
            end
        end
    end

    initial begin : main
        bit ok;
        lcg_state     = 32'd40386;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        window_seen   = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_window     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        run_tests(ok);
        $display("Error counts: %0d mismatches, %0d other, %0d property failures",
                 mismatch_cnt, other_err_cnt, UUT.u_props.prop_fail_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0 && UUT.u_props.prop_fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/conv_layer_props.sv */
`default_nettype none

module conv_layer_props (
    input logic                clk,           // Layer clock
    input logic                rst_n,         // Sync reset, active low
    input logic                in_valid,      // Window strobe
    input logic                busy,          // Layer busy
    input logic                out_valid,     // Output strobe
    input conv_pkg::filt_idx_t out_filter     // Filter of output
);

    int   prop_fail_cnt = 0;                  // Read by the testbench
    logic accept;                             // Window taken on this edge

    assign accept = in_valid && !busy;

    // Filter 0 comes out 2 edges after the accepting edge
    a_first_filter: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept, 3) |-> (out_valid && out_filter == '0))
        else begin
            prop_fail_cnt++;
            $error("Filter 0 missing after an accepted window");
        end

    // Filter 0 only for an accepted window
    a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_filter == '0) |-> $past(accept, 3))
        else begin
            prop_fail_cnt++;
            $error("Filter 0 out without an accepted window");
        end

    // Remaining filters follow in order with no gap
    a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_filter != conv_pkg::filt_idx_t'(conv_pkg::NUM_FILTERS - 1))
        |=> (out_valid && out_filter == $past(out_filter) + 1'b1))
        else begin
            prop_fail_cnt++;
            $error("Filter results out of order or not consecutive");
        end

    // Busy through the first issues, low for the last one
    a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(accept, 1) || $past(accept, 2) || $past(accept, 3)) |-> busy)
        else begin
            prop_fail_cnt++;
            $error("Busy low while filters were pending");
        end

    a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept, 4) |-> !busy)
        else begin
            prop_fail_cnt++;
            $error("Busy still high on the last filter issue");
        end

endmodule

bind conv_layer conv_layer_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .busy       (busy),
    .out_valid  (out_valid),
    .out_filter (out_filter)
);

`default_nettype wire

/* hw/conv_layer.sv */
`default_nettype none

module conv_layer (
    input  logic                  clk,          // Layer clock
    input  logic                  rst_n,        // Sync reset, active low
    input  logic                  in_valid,     // Single-cycle window strobe
    input  conv_pkg::act_window_t in_window,    // Valid with in_valid only
    output logic                  busy,         // Strobes now are dropped
    output logic                  out_valid,    // One pulse per filter
    output conv_pkg::filt_idx_t   out_filter,   // Filter of out_value
    output conv_pkg::out_t        out_value     // Requantized result
);

    // Sequencer to MAC
    logic                load;                  // Window accepted
    logic                issue;                 // Filter issued
    conv_pkg::filt_idx_t issue_filter;          // Issued filter

    // MAC to requantizer
    logic                mac_valid;             // Sum ready
    conv_pkg::acc_t      mac_sum;               // Raw sum
    conv_pkg::filt_idx_t mac_filter;            // Filter of raw sum

    // Accepts windows, one filter per cycle
    conv_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .load         (load),
        .issue        (issue),
        .issue_filter (issue_filter),
        .busy         (busy)
    );

    // Shared MAC array, 1 cycle after issue
    filter_mac u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .in_window    (in_window),
        .issue        (issue),
        .issue_filter (issue_filter),
        .mac_valid    (mac_valid),
        .mac_sum      (mac_sum),
        .mac_filter   (mac_filter)
    );

    // Shift and clip, 1 more cycle
    requantizer u_rq (
        .clk          (clk),
        .rst_n        (rst_n),
        .mac_valid    (mac_valid),
        .mac_sum      (mac_sum),
        .mac_filter   (mac_filter),
        .out_valid    (out_valid),
        .out_value    (out_value),
        .out_filter   (out_filter)
    );

endmodule

`default_nettype wire

/* hw/requantizer.sv */
`default_nettype none

module requantizer (
    input  logic                clk,          // Layer clock
    input  logic                rst_n,        // Sync reset, active low
    input  logic                mac_valid,    // mac_sum is a result
    input  conv_pkg::acc_t      mac_sum,      // Raw filter sum
    input  conv_pkg::filt_idx_t mac_filter,   // Filter of mac_sum
    output logic                out_valid,    // Output strobe
    output conv_pkg::out_t      out_value,    // Requantized result
    output conv_pkg::filt_idx_t out_filter    // Filter of out_value
);

    conv_pkg::acc_t shifted;                  // Sum after rescale
    conv_pkg::out_t sat_value;                // Clipped result

    // Floor division by 2^OUT_SHIFT
    assign shifted = mac_sum >>> conv_pkg::OUT_SHIFT;

    // Symmetric clip, -128 is never produced
    always_comb begin
        if (shifted > conv_pkg::SAT_MAX) begin
            sat_value = conv_pkg::out_t'(conv_pkg::SAT_MAX);
        end else if (shifted < -conv_pkg::SAT_MAX) begin
            sat_value = conv_pkg::out_t'(-conv_pkg::SAT_MAX);
        end else begin
            sat_value = conv_pkg::out_t'(shifted);  // In range, low byte is exact
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid) begin
            out_value  <= sat_value;
            out_filter <= mac_filter;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mac_valid;               // One result per MAC result
        end
    end

endmodule

`default_nettype wire

/* hw/filter_mac.sv */
`default_nettype none

module filter_mac (
    input  logic                  clk,            // Layer clock
    input  logic                  rst_n,          // Sync active-low reset
    input  logic                  load,           // Capture in_window
    input  conv_pkg::act_window_t in_window,      // Activations indexed [ch][tap]
    input  logic                  issue,          // Compute a filter
    input  conv_pkg::filt_idx_t   issue_filter,   // Which filter
    output logic                  mac_valid,      // mac_sum holds a result
    output conv_pkg::acc_t        mac_sum,        // Full sum for mac_filter
    output conv_pkg::filt_idx_t   mac_filter      // Filter of mac_sum
);

    conv_pkg::act_window_t win_q;                 // Latched window

    // Weights of the issued filter
    logic signed [conv_pkg::WGT_W-1:0] wsel [conv_pkg::NUM_CH][conv_pkg::KERNEL_TAPS];

    // One product per channel and tap
    conv_pkg::acc_t prod [conv_pkg::NUM_CH][conv_pkg::KERNEL_TAPS];

    conv_pkg::acc_t sum_next;                     // Sum across all products

    // New load may share the edge with the last issue
    always_ff @(posedge clk) begin
        if (load) begin
            win_q <= in_window;
        end
    end

    // Weight select from the fixed table
    always_comb begin
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                wsel[c][t] = conv_pkg::WEIGHTS[issue_filter][c][t];
            end
        end
    end

    // Activation zero-extended so it stays positive in the signed product
    always_comb begin
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                prod[c][t] = $signed({1'b0, win_q[c][t]}) * wsel[c][t];
            end
        end
    end

    // Adder tree over channels and taps
    always_comb begin
        sum_next = '0;
        for (int c = 0; c < conv_pkg::NUM_CH; c++) begin
            for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
                sum_next = sum_next + prod[c][t];
            end
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (issue) begin
            mac_sum    <= sum_next;
            mac_filter <= issue_filter;
        end
    end

    // Valid tracks issue one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= issue;
        end
    end

endmodule

`default_nettype wire

/* hw/conv_sequencer.sv */
`default_nettype none

module conv_sequencer (
    input  logic                clk,            // Layer clock
    input  logic                rst_n,          // Sync reset, active low
    input  logic                in_valid,       // Window strobe
    output logic                load,           // Latch window into MAC
    output logic                issue,          // A filter is computed this cycle
    output conv_pkg::filt_idx_t issue_filter,   // Filter computed this cycle
    output logic                busy            // Window strobes dropped
);

    conv_pkg::seq_state_t state;                // Idle or issuing
    conv_pkg::filt_idx_t  filt_cnt;             // Next filter to issue
    logic                 last_filt;            // Final issue of current window

    // Last filter of the window is on the MAC this cycle
    assign last_filt = (state == conv_pkg::SEQ_RUN) &&
                       (filt_cnt == conv_pkg::filt_idx_t'(conv_pkg::NUM_FILTERS - 1));

    // Busy drops during the last issue so the next window
    // is taken on the same edge and results stay back-to-back
    assign busy = (state == conv_pkg::SEQ_RUN) && !last_filt;

    assign load         = in_valid && !busy;    // Accept edge
    assign issue        = (state == conv_pkg::SEQ_RUN);
    assign issue_filter = filt_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= conv_pkg::SEQ_IDLE;
            filt_cnt <= '0;
        end else if (load) begin
            state    <= conv_pkg::SEQ_RUN;      // New window starts at filter 0
            filt_cnt <= '0;
        end else if (state == conv_pkg::SEQ_RUN) begin
            if (last_filt) begin
                state    <= conv_pkg::SEQ_IDLE; // Window done
                filt_cnt <= '0;
            end else begin
                filt_cnt <= filt_cnt + 1'b1;    // Step to next filter
            end
        end
    end

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Layer geometry
    localparam int NUM_CH      = 4;      // Input channels
    localparam int KERNEL_TAPS = 5;      // Taps per channel
    localparam int NUM_FILTERS = 4;      // Output filters, one per cycle

    // Datapath widths
    localparam int ACT_W       = 8;      // Activation, unsigned
    localparam int WGT_W       = 8;      // Weight, signed
    localparam int ACC_W       = 22;     // 20 products of 255 x -128 fit with margin
    localparam int OUT_W       = 8;      // Requantized output, signed
    localparam int FILT_IDX_W  = 2;      // Enough for NUM_FILTERS

    // Requantization
    localparam int OUT_SHIFT   = 7;      // Arithmetic right shift of the sum
    localparam int SAT_MAX     = 127;    // Symmetric clip, -128 never produced

    // Window of activations, indexed [channel][tap]
    typedef logic [NUM_CH-1:0][KERNEL_TAPS-1:0][ACT_W-1:0] act_window_t;

    typedef logic [FILT_IDX_W-1:0]   filt_idx_t;   // Filter number
    typedef logic signed [ACC_W-1:0] acc_t;        // MAC sum
    typedef logic signed [OUT_W-1:0] out_t;        // Layer output

    typedef enum logic {
        SEQ_IDLE = 1'b0,                 // Waiting for a window
        SEQ_RUN  = 1'b1                  // Issuing filters
    } seq_state_t;

    // Fixed weight table, indexed [filter][channel][tap]
    // Tap 0 is listed first in each row
    localparam logic signed [WGT_W-1:0] WEIGHTS [NUM_FILTERS][NUM_CH][KERNEL_TAPS] = '{
        '{                               // Filter 0
            '{ -6,  23,  34,  16,   0},  // Ch 0
            '{-13,  18,   0, -51,  -9},  // Ch 1
            '{ 14,  18,  37,  21,  31},  // Ch 2
            '{-20,  17,   3,   0, -17}   // Ch 3
        },
        '{                               // Filter 1
            '{-29,  -1,  -4,  11, -17},  // Ch 0
            '{ 11,   1,  19, -25, -16},  // Ch 1
            '{ 31,  16,  -5,  -8, -21},  // Ch 2
            '{ 13, -23,   2,   8, -29}   // Ch 3
        },
        '{                               // Filter 2
            '{ 24,  13,   9, -33, -67},  // Ch 0
            '{ 25,   7, -15, -32, -15},  // Ch 1
            '{  8,  -4, -14, -49, -24},  // Ch 2
            '{ 12,  22,  13, -31,  10}   // Ch 3
        },
        '{                               // Filter 3
            '{-10,  -4, -24,   0,   2},  // Ch 0
            '{ 20, -21, -30,   6,  10},  // Ch 1
            '{ 20, -18, -74,   1, -13},  // Ch 2
            '{ -4,   0, -64,  27,  13}   // Ch 3
        }
    };

endpackage

`default_nettype wire
